//--- design/asteroid_pkg.sv
package asteroid_pkg;

    // table sizes
    localparam int n_asteroids = 8;
    localparam int n_shots     = 8;
    localparam int index_width = 3;
    localparam int pos_width   = 8;

    // ship lives
    localparam int lives_width = 2;
    localparam logic [lives_width-1:0] lives_init = 2'd3;

    typedef logic [pos_width-1:0] position_t;

    // encodings double as the debug codes on db_state
    typedef enum logic [4:0] {
        idle_init        = 5'd0,
        wait_start       = 5'd1,
        clear_index      = 5'd2,
        compare_ship     = 5'd3,
        lose_life        = 5'd4,
        destroy_asteroid = 5'd5,
        save_destroy     = 5'd6,
        start_shots      = 5'd7,
        wait_shots       = 5'd8,
        next_asteroid    = 5'd9,
        finish           = 5'd10
    } state_t;

endpackage

//--- design/collision_ctrl_if.sv
interface collision_ctrl_if;

    // strobes from the control unit
    logic clear_index;
    logic next_index;
    logic lose_life;
    logic destroy;

    // status levels from the datapath
    logic ship_hit;
    logic last_index;
    logic lives_left;

    modport control (
        output clear_index,
        output next_index,
        output lose_life,
        output destroy,
        input  ship_hit,
        input  last_index,
        input  lives_left
    );

    modport datapath (
        input  clear_index,
        input  next_index,
        input  lose_life,
        input  destroy,
        output ship_hit,
        output last_index,
        output lives_left
    );

endinterface

//--- design/shot_scan_if.sv
interface shot_scan_if;

    logic scan_start;

    // whole asteroid table, one slot per packed element
    asteroid_pkg::position_t [asteroid_pkg::n_asteroids-1:0] asteroid_positions;
    logic [asteroid_pkg::n_asteroids-1:0] alive_mask;

    // result, qualified by scan_done
    logic [asteroid_pkg::n_asteroids-1:0] hit_mask;
    logic scan_done;

    modport datapath (
        output scan_start,
        output asteroid_positions,
        output alive_mask,
        input  hit_mask,
        input  scan_done
    );

    modport scanner (
        input  scan_start,
        input  asteroid_positions,
        input  alive_mask,
        output hit_mask,
        output scan_done
    );

endinterface

//--- design/collision_control.sv
module collision_control (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    collision_ctrl_if.control     ctrl,
    output logic                  start_shots,
    input  logic                  scan_done,
    output logic                  busy,
    output logic                  done,
    output logic                  game_over,
    output asteroid_pkg::state_t  db_state
);

    asteroid_pkg::state_t state;
    asteroid_pkg::state_t state_next;

    // ------------------------------------------------------------------
    // state register and game over flag
    // ------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= asteroid_pkg::wait_start;
        end else begin
            state <= state_next;
        end
    end

    // only reset brings the game back
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            game_over <= 1'b0;
        end else if (state == asteroid_pkg::lose_life && !ctrl.lives_left) begin
            game_over <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // transitions
    // ------------------------------------------------------------------
    always_comb begin
        case (state)
            asteroid_pkg::idle_init:
                state_next = asteroid_pkg::wait_start;
            asteroid_pkg::wait_start:
                state_next = (start && !game_over) ? asteroid_pkg::clear_index
                                                   : asteroid_pkg::wait_start;
            asteroid_pkg::clear_index:
                state_next = asteroid_pkg::compare_ship;
            asteroid_pkg::compare_ship:
                if (ctrl.ship_hit) begin
                    state_next = asteroid_pkg::lose_life;
                end else if (ctrl.last_index) begin
                    state_next = asteroid_pkg::start_shots;
                end else begin
                    state_next = asteroid_pkg::next_asteroid;
                end
            // lives_left already reflects the decrement here
            asteroid_pkg::lose_life:
                state_next = ctrl.lives_left ? asteroid_pkg::destroy_asteroid
                                             : asteroid_pkg::finish;
            asteroid_pkg::destroy_asteroid:
                state_next = asteroid_pkg::save_destroy;
            asteroid_pkg::save_destroy:
                state_next = ctrl.last_index ? asteroid_pkg::start_shots
                                             : asteroid_pkg::next_asteroid;
            asteroid_pkg::start_shots:
                state_next = asteroid_pkg::wait_shots;
            asteroid_pkg::wait_shots:
                state_next = scan_done ? asteroid_pkg::finish : asteroid_pkg::wait_shots;
            asteroid_pkg::next_asteroid:
                state_next = asteroid_pkg::compare_ship;
            asteroid_pkg::finish:
                state_next = asteroid_pkg::wait_start;
            default:
                state_next = asteroid_pkg::idle_init;
        endcase
    end

    // ------------------------------------------------------------------
    // moore outputs
    // ------------------------------------------------------------------
    always_comb begin
        ctrl.clear_index = (state == asteroid_pkg::clear_index);
        ctrl.next_index  = (state == asteroid_pkg::next_asteroid);
        ctrl.lose_life   = (state == asteroid_pkg::lose_life);
        ctrl.destroy     = (state == asteroid_pkg::destroy_asteroid);
        start_shots      = (state == asteroid_pkg::start_shots);
        done             = (state == asteroid_pkg::finish);
        // busy drops in finish, together with done
        busy             = !(state inside {asteroid_pkg::idle_init,
                                           asteroid_pkg::wait_start,
                                           asteroid_pkg::finish});
        db_state         = state;
    end

endmodule

//--- design/collision_datapath.sv
module collision_datapath (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    load_asteroid,
    input  logic [asteroid_pkg::index_width-1:0]    asteroid_index,
    input  asteroid_pkg::position_t                 asteroid_position,
    input  asteroid_pkg::position_t                 ship_position,
    input  logic                                    busy,
    input  logic                                    start_shots,
    collision_ctrl_if.datapath                      ctrl,
    shot_scan_if.datapath                           scan,
    output logic [asteroid_pkg::lives_width-1:0]    lives,
    output logic [asteroid_pkg::n_asteroids-1:0]    alive_mask
);

    asteroid_pkg::position_t [asteroid_pkg::n_asteroids-1:0] positions;
    asteroid_pkg::position_t ship_latched;
    logic [asteroid_pkg::index_width-1:0] index;
    logic [asteroid_pkg::lives_width-1:0] lives_after;

    // ------------------------------------------------------------------
    // asteroid table
    // ------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (load_asteroid && !busy) begin
            positions[asteroid_index] <= asteroid_position;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alive_mask <= '0;
        end else if (load_asteroid && !busy) begin
            alive_mask[asteroid_index] <= 1'b1;
        end else if (ctrl.destroy) begin
            alive_mask[index] <= 1'b0;
        end else if (scan.scan_done) begin
            alive_mask <= alive_mask & ~scan.hit_mask;
        end
    end

    // ------------------------------------------------------------------
    // index, ship latch and lives
    // ------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            index <= '0;
        end else if (ctrl.clear_index) begin
            index <= '0;
        end else if (ctrl.next_index) begin
            index <= index + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.clear_index) begin
            ship_latched <= ship_position;
        end
    end

    // look ahead so the control sees the count after this decrement
    assign lives_after = ctrl.lose_life ? lives - 1'b1 : lives;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lives <= asteroid_pkg::lives_init;
        end else if (ctrl.lose_life) begin
            lives <= lives_after;
        end
    end

    assign ctrl.ship_hit   = alive_mask[index] && (positions[index] == ship_latched);
    assign ctrl.last_index = (index == asteroid_pkg::index_width'(asteroid_pkg::n_asteroids - 1));
    assign ctrl.lives_left = (lives_after != '0);

    // shot scanner side
    assign scan.scan_start         = start_shots;
    assign scan.asteroid_positions = positions;
    assign scan.alive_mask         = alive_mask;

endmodule

//--- design/shot_scanner.sv
module shot_scanner (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    load_shot,
    input  logic [asteroid_pkg::index_width-1:0]    shot_index,
    input  asteroid_pkg::position_t                 shot_position,
    input  logic                                    busy,
    shot_scan_if.scanner                            scan,
    output logic [asteroid_pkg::n_shots-1:0]        shot_valid_mask
);

    asteroid_pkg::position_t shot_table [asteroid_pkg::n_shots];
    logic [asteroid_pkg::index_width-1:0] scan_index;
    logic [asteroid_pkg::n_asteroids-1:0] alive_snapshot;
    logic [asteroid_pkg::n_asteroids-1:0] hit_acc;
    logic [asteroid_pkg::n_asteroids-1:0] shot_match;
    logic scanning;
    logic scan_finish;
    logic shot_hits;

    always_ff @(posedge clock) begin
        if (load_shot && !busy) begin
            shot_table[shot_index] <= shot_position;
        end
    end

    // current shot against every asteroid alive at scan_start
    always_comb begin
        for (int a = 0; a < asteroid_pkg::n_asteroids; a++) begin
            shot_match[a] = alive_snapshot[a]
                         && (scan.asteroid_positions[a] == shot_table[scan_index]);
        end
    end

    assign shot_hits = scanning && shot_valid_mask[scan_index] && (|shot_match);

    // ------------------------------------------------------------------
    // sequencing: one shot per cycle, done one cycle after the last
    // ------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            scanning    <= 1'b0;
            scan_finish <= 1'b0;
            scan_index  <= '0;
        end else begin
            scan_finish <= 1'b0;
            if (scan.scan_start) begin
                scanning   <= 1'b1;
                scan_index <= '0;
            end else if (scanning) begin
                scan_index <= scan_index + 1'b1;
                if (scan_index == asteroid_pkg::index_width'(asteroid_pkg::n_shots - 1)) begin
                    scanning    <= 1'b0;
                    scan_finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (scan.scan_start) begin
            alive_snapshot <= scan.alive_mask;
            hit_acc        <= '0;
        end else if (shot_hits) begin
            hit_acc <= hit_acc | shot_match;
        end
    end

    // a hitting shot is consumed
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            shot_valid_mask <= '0;
        end else if (load_shot && !busy) begin
            shot_valid_mask[shot_index] <= 1'b1;
        end else if (shot_hits) begin
            shot_valid_mask[scan_index] <= 1'b0;
        end
    end

    assign scan.hit_mask  = hit_acc;
    assign scan.scan_done = scan_finish;

endmodule

//--- design/asteroid_collision_top.sv
module asteroid_collision_top (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    load_asteroid,
    input  logic [asteroid_pkg::index_width-1:0]    asteroid_index,
    input  asteroid_pkg::position_t                 asteroid_position,
    input  logic                                    load_shot,
    input  logic [asteroid_pkg::index_width-1:0]    shot_index,
    input  asteroid_pkg::position_t                 shot_position,
    input  logic                                    start,
    input  asteroid_pkg::position_t                 ship_position,
    output logic                                    busy,
    output logic                                    done,
    output logic [asteroid_pkg::lives_width-1:0]    lives,
    output logic                                    game_over,
    output logic [asteroid_pkg::n_asteroids-1:0]    alive_mask,
    output logic [asteroid_pkg::n_shots-1:0]        shot_valid_mask,
    output asteroid_pkg::state_t                    db_state
);

    logic start_shots;

    collision_ctrl_if ctrl_bus ();
    shot_scan_if      scan_bus ();

    collision_control control_i (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .ctrl        (ctrl_bus.control),
        .start_shots (start_shots),
        .scan_done   (scan_bus.scan_done),
        .busy        (busy),
        .done        (done),
        .game_over   (game_over),
        .db_state    (db_state)
    );

    collision_datapath datapath_i (
        .clock             (clock),
        .reset             (reset),
        .load_asteroid     (load_asteroid),
        .asteroid_index    (asteroid_index),
        .asteroid_position (asteroid_position),
        .ship_position     (ship_position),
        .busy              (busy),
        .start_shots       (start_shots),
        .ctrl              (ctrl_bus.datapath),
        .scan              (scan_bus.datapath),
        .lives             (lives),
        .alive_mask        (alive_mask)
    );

    shot_scanner scanner_i (
        .clock           (clock),
        .reset           (reset),
        .load_shot       (load_shot),
        .shot_index      (shot_index),
        .shot_position   (shot_position),
        .busy            (busy),
        .scan            (scan_bus.scanner),
        .shot_valid_mask (shot_valid_mask)
    );

endmodule

//--- verification/asteroid_collision_sva.sv
module asteroid_collision_sva (
    input logic                                 clock,
    input logic                                 reset,
    input logic                                 busy,
    input logic                                 done,
    input logic [asteroid_pkg::lives_width-1:0] lives,
    input logic [asteroid_pkg::n_asteroids-1:0] alive_mask,
    input asteroid_pkg::state_t                 db_state
);

    int failure_count = 0;

    // ------------------------------------------------------------------
    // end of pass
    // ------------------------------------------------------------------
    done_single_a: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failure_count++;
        end

    done_busy_a: assert property (@(posedge clock) disable iff (reset) done |-> $fell(busy))
        else begin
            $error("done did not coincide with busy falling");
            failure_count++;
        end

    // ------------------------------------------------------------------
    // state and counters
    // ------------------------------------------------------------------
    lives_a: assert property (@(posedge clock) disable iff (reset) lives <= $past(lives))
        else begin
            $error("lives increased outside reset");
            failure_count++;
        end

    state_a: assert property (@(posedge clock) disable iff (reset)
                              db_state <= asteroid_pkg::finish)
        else begin
            $error("db_state holds an unlisted encoding");
            failure_count++;
        end

    // a destroyed asteroid shows up one cycle after the busy strobe
    alive_a: assert property (@(posedge clock) disable iff (reset)
                              (|($past(alive_mask) & ~alive_mask)) |-> $past(busy))
        else begin
            $error("an alive flag fell while the pass was idle");
            failure_count++;
        end

endmodule

bind asteroid_collision_top asteroid_collision_sva sva_i (.*);

//--- verification/tb_asteroid_collision.sv
module tb_asteroid_collision;

    // room for twelve passes of up to 60 cycles plus loads and idle time
    localparam int timeout_cycles = 3000;

    logic clock;
    logic reset;
    logic load_asteroid;
    logic [2:0] asteroid_index;
    asteroid_pkg::position_t asteroid_position;
    logic load_shot;
    logic [2:0] shot_index;
    asteroid_pkg::position_t shot_position;
    logic start;
    asteroid_pkg::position_t ship_position;
    logic busy;
    logic done;
    logic [1:0] lives;
    logic game_over;
    logic [7:0] alive_mask;
    logic [7:0] shot_valid_mask;
    asteroid_pkg::state_t db_state;

    // reference model
    asteroid_pkg::position_t ref_pos [8];
    asteroid_pkg::position_t ref_shot [8];
    logic [7:0] ref_alive;
    logic [7:0] ref_valid;
    logic [1:0] ref_lives;
    logic ref_over;

    logic [31:0] lcg_state = 32'd36406;
    int cycle_count = 0;

    asteroid_collision_top dut_i (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // bound concurrent assertions
    always @(negedge clock) begin
        if (dut_i.sva_i.failure_count != 0) begin
            abort_run("a concurrent assertion on the DUT failed");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // low bits carry the slot so positions never collide by accident
    function automatic logic [7:0] make_position(input logic [2:0] slot);
        logic [7:0] r;
        r = lcg_next();
        return {r[7:3], slot};
    endfunction

    function automatic bit ship_matches(input logic [7:0] ship);
        bit hit;
        hit = 0;
        for (int i = 0; i < 8; i++) begin
            if (ref_alive[i] && ref_pos[i] == ship) begin
                hit = 1;
            end
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h",
                                     $time, name, expected, actual));
    endtask

    task automatic check_outputs();
        check_value("alive_mask", ref_alive, alive_mask);
        check_value("shot_valid_mask", ref_valid, shot_valid_mask);
        check_value("lives", ref_lives, lives);
        check_value("game_over", ref_over, game_over);
    endtask

    task automatic load_asteroid_slot(input logic [2:0] slot, input logic [7:0] pos);
        @(posedge clock);
        load_asteroid     <= 1'b1;
        asteroid_index    <= slot;
        asteroid_position <= pos;
        @(posedge clock);
        load_asteroid <= 1'b0;
        ref_pos[slot]   = pos;
        ref_alive[slot] = 1'b1;
    endtask

    task automatic load_shot_slot(input logic [2:0] slot, input logic [7:0] pos);
        @(posedge clock);
        load_shot     <= 1'b1;
        shot_index    <= slot;
        shot_position <= pos;
        @(posedge clock);
        load_shot <= 1'b0;
        ref_shot[slot]  = pos;
        ref_valid[slot] = 1'b1;
    endtask

    // ship pass then shot pass on the model tables
    task automatic apply_pass_rules(input logic [7:0] ship);
        logic [7:0] snapshot;
        logic [7:0] hits;
        logic [7:0] match;
        for (int i = 0; i < 8; i++) begin
            if (!ref_over && ref_alive[i] && ref_pos[i] == ship) begin
                ref_lives = ref_lives - 1'b1;
                if (ref_lives == 0) begin
                    ref_over = 1'b1;
                end else begin
                    ref_alive[i] = 1'b0;
                end
            end
        end
        if (!ref_over) begin
            snapshot = ref_alive;
            hits     = '0;
            for (int s = 0; s < 8; s++) begin
                match = '0;
                for (int a = 0; a < 8; a++) begin
                    match[a] = snapshot[a] && (ref_pos[a] == ref_shot[s]);
                end
                if (ref_valid[s] && match != 0) begin
                    hits         = hits | match;
                    ref_valid[s] = 1'b0;
                end
            end
            ref_alive = ref_alive & ~hits;
        end
    endtask

    // meddle adds loads, a second start and a new ship position while busy
    task automatic run_pass(input logic [7:0] ship, input bit meddle);
        apply_pass_rules(ship);
        @(posedge clock);
        start         <= 1'b1;
        ship_position <= ship;
        @(posedge clock);
        start <= 1'b0;
        if (meddle) begin
            @(posedge clock);
            start             <= 1'b1;
            ship_position     <= ~ship;
            load_asteroid     <= 1'b1;
            asteroid_index    <= 3'd5;
            asteroid_position <= ship;
            load_shot         <= 1'b1;
            shot_index        <= 3'd0;
            shot_position     <= ship;
            @(posedge clock);
            start         <= 1'b0;
            load_asteroid <= 1'b0;
            load_shot     <= 1'b0;
        end
        do @(negedge clock); while (!done);
        check_outputs();
        check_value("db_state", asteroid_pkg::finish, db_state);
    endtask

    initial begin
        logic [2:0] slot;
        logic [7:0] pick;
        logic [7:0] ship;
        clock             = 1'b0;
        reset             = 1'b1;
        load_asteroid     = 1'b0;
        asteroid_index    = '0;
        asteroid_position = '0;
        load_shot         = 1'b0;
        shot_index        = '0;
        shot_position     = '0;
        start             = 1'b0;
        ship_position     = '0;
        ref_alive = '0;
        ref_valid = '0;
        ref_lives = asteroid_pkg::lives_init;
        ref_over  = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        check_outputs();
        check_value("done", 0, done);
        check_value("db_state", asteroid_pkg::wait_start, db_state);

        // ----------------------------------------------------------------------
        // quiet pass then shots
        // ----------------------------------------------------------------------
        for (int i = 0; i < 8; i++) begin
            load_asteroid_slot(3'(i), make_position(3'(i)));
        end
        run_pass(ref_pos[0] ^ 8'h08, 1'b0);

        // shots 0 and 1 both hit asteroid 5 and shot 2 misses
        load_shot_slot(3'd0, ref_pos[5]);
        load_shot_slot(3'd1, ref_pos[5]);
        load_shot_slot(3'd2, ref_pos[6] ^ 8'h08);
        load_shot_slot(3'd3, ref_pos[7]);
        run_pass(ref_pos[0] ^ 8'h08, 1'b0);

        // ----------------------------------------------------------------------
        // random passes with the ship kept clear so lives survive
        // ----------------------------------------------------------------------
        for (int r = 0; r < 6; r++) begin
            repeat (3) begin
                pick = lcg_next();
                slot = {1'b0, pick[1:0]};
                load_asteroid_slot(slot, make_position(slot));
            end
            repeat (3) begin
                pick = lcg_next();
                slot = {1'b1, pick[1:0]};
                if (pick[4]) begin
                    load_shot_slot(slot, ref_pos[pick[7:5]]);
                end else begin
                    load_shot_slot(slot, lcg_next());
                end
            end
            ship = lcg_next();
            if (ship_matches(ship)) begin
                ship = ship ^ 8'h08;
            end
            run_pass(ship, 1'b0);
        end

        // ----------------------------------------------------------------------
        // ship hits down to game over
        // ----------------------------------------------------------------------
        load_asteroid_slot(3'd3, make_position(3'd3));
        run_pass(ref_pos[3], 1'b1);
        load_asteroid_slot(3'd1, make_position(3'd1));
        run_pass(ref_pos[1], 1'b0);

        load_asteroid_slot(3'd6, make_position(3'd6));
        load_asteroid_slot(3'd2, make_position(3'd2));
        load_shot_slot(3'd3, ref_pos[6]);
        run_pass(ref_pos[2], 1'b0);

        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        repeat (100) begin
            @(negedge clock);
            assert (!done && !busy)
                else abort_run("a start after game over began a new pass");
        end
        check_outputs();
        check_value("db_state", asteroid_pkg::wait_start, db_state);

        if (dut_i.sva_i.failure_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("concurrent assertions reported failures during the run");
        end
    end

endmodule

//--- asteroid_collision.f
design/asteroid_pkg.sv
design/collision_ctrl_if.sv
design/shot_scan_if.sv
design/collision_control.sv
design/collision_datapath.sv
design/shot_scanner.sv
design/asteroid_collision_top.sv
verification/asteroid_collision_sva.sv
verification/tb_asteroid_collision.sv
